//--- design/llc_params.svh
// size definitions for the cache slice tag, state and data store
// ways, set and tag widths, line and sharer widths, RAM banking

`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// associativity
`define LLC_WAYS 4
`define LLC_WAY_BITS 2

// 64 sets
`define LLC_SET_BITS 6
`define LLC_TAG_BITS 10
`define LLC_LINE_BITS 32
`define LLC_SHARER_BITS 4

// each way is split into banks by the top set bit
`define LLC_BANKS 2
`define LLC_BANK_ADDR_BITS (`LLC_SET_BITS - 1)

// tag, 2-bit state and dirty bit share one RAM word
`define LLC_MIXED_BITS (`LLC_TAG_BITS + 3)

`endif

//--- design/llc_pkg.sv
// vector types, mixed word field positions and enums for the cache store

`include "llc_params.svh"

package llc_pkg;

    typedef logic [`LLC_SET_BITS-1:0]    set_t;
    typedef logic [`LLC_TAG_BITS-1:0]    tag_t;
    typedef logic [`LLC_WAY_BITS-1:0]    way_t;
    typedef logic [`LLC_LINE_BITS-1:0]   line_t;
    typedef logic [`LLC_SHARER_BITS-1:0] sharers_t;
    typedef logic [`LLC_MIXED_BITS-1:0]  mixed_t;

    // layout of mixed_t, tag in the low bits and dirty on top
    localparam int MIXED_TAG_LO   = 0;
    localparam int MIXED_TAG_HI   = `LLC_TAG_BITS - 1;
    localparam int MIXED_STATE_LO = `LLC_TAG_BITS;
    localparam int MIXED_STATE_HI = `LLC_TAG_BITS + 1;
    localparam int MIXED_DIRTY    = `LLC_TAG_BITS + 2;

    typedef enum logic [1:0] {
        INVALID  = 2'd0,
        VALID    = 2'd1,
        SHARED   = 2'd2,
        MODIFIED = 2'd3
    } llc_state_e;

    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_FILL   = 2'd1,
        OP_UPDATE = 2'd2,
        OP_FLUSH  = 2'd3
    } llc_op_e;

endpackage

//--- design/llc_mem_if.sv
// memory bus between request decode, the banked store and the result stage

`timescale 1ns/1ns
`include "llc_params.svh"

interface llc_mem_if;
    // request side
    llc_pkg::set_t                                  set;
    logic                                           rd_en;
    llc_pkg::tag_t                                  lookup_tag;
    logic [`LLC_WAYS-1:0]                           mixed_we;
    logic [`LLC_WAYS-1:0]                           sharers_we;
    logic [`LLC_WAYS-1:0]                           line_we;
    logic [`LLC_SET_BITS-`LLC_BANK_ADDR_BITS-1:0]   bank;
    llc_pkg::mixed_t                                mixed_mask;
    llc_pkg::mixed_t                                mixed_wdata;
    llc_pkg::sharers_t                              sharers_wdata;
    llc_pkg::line_t                                 line_wdata;
    logic                                           evict_we;
    llc_pkg::way_t                                  evict_wdata;

    // registered read data, one entry per way
    llc_pkg::mixed_t                                mixed_rd [`LLC_WAYS];
    llc_pkg::sharers_t                              sharers_rd [`LLC_WAYS];
    llc_pkg::line_t                                 line_rd [`LLC_WAYS];
    llc_pkg::way_t                                  evict_rd;

    modport ctrl (output set, rd_en, lookup_tag, mixed_we, sharers_we, line_we, bank,
                  mixed_mask, mixed_wdata, sharers_wdata, line_wdata, evict_we, evict_wdata);

    modport mem (input set, rd_en, mixed_we, sharers_we, line_we, bank, mixed_mask,
                 mixed_wdata, sharers_wdata, line_wdata, evict_we, evict_wdata,
                 output mixed_rd, sharers_rd, line_rd, evict_rd);

    modport rsp (input rd_en, lookup_tag, mixed_rd, sharers_rd, line_rd, evict_rd);
endinterface

//--- design/llc_sram_sp.sv
// single-port synchronous RAM with chip enable and per-bit write mask

`timescale 1ns/1ns

module llc_sram_sp #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     ce,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         d,
    input  logic [WIDTH-1:0]         wmask,
    output logic [WIDTH-1:0]         q
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read-first: q returns the word as it was before a write in the same cycle
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~wmask) | (d & wmask);
            end
            q <= mem[addr];
        end
    end

endmodule

//--- design/llc_req_decode.sv
// request decode into way and bank write enables, masks and packed write words

`timescale 1ns/1ns
`include "llc_params.svh"

module llc_req_decode (
    input logic                 req_valid,
    input llc_pkg::llc_op_e     req_op,
    input llc_pkg::set_t        req_set,
    input llc_pkg::tag_t        req_tag,
    input llc_pkg::way_t        req_way,
    input llc_pkg::line_t       req_line,
    input llc_pkg::llc_state_e  req_state,
    input logic                 req_dirty,
    input llc_pkg::sharers_t    req_sharers,
    llc_mem_if.ctrl             mem
);

    logic                 is_fill;
    logic                 is_update;
    logic                 is_flush;
    logic [`LLC_WAYS-1:0] way_sel;

    assign is_fill   = req_valid && (req_op == llc_pkg::OP_FILL);
    assign is_update = req_valid && (req_op == llc_pkg::OP_UPDATE);
    assign is_flush  = req_valid && (req_op == llc_pkg::OP_FLUSH);

    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            way_sel[w] = (is_fill || is_update) && (req_way == llc_pkg::way_t'(w));
        end
    end

    assign mem.set        = req_set;
    assign mem.rd_en      = req_valid && (req_op == llc_pkg::OP_LOOKUP);
    assign mem.lookup_tag = req_tag;
    assign mem.bank       = req_set[`LLC_SET_BITS-1:`LLC_BANK_ADDR_BITS];

    // flush hits every way of the set
    assign mem.mixed_we   = way_sel | {`LLC_WAYS{is_flush}};
    assign mem.sharers_we = way_sel | {`LLC_WAYS{is_flush}};
    assign mem.line_we    = is_fill ? way_sel : '0;

    always_comb begin
        mem.mixed_mask = '0;
        if (is_fill) begin
            mem.mixed_mask[llc_pkg::MIXED_TAG_HI:llc_pkg::MIXED_TAG_LO] = '1;
        end
        if (is_fill || is_update || is_flush) begin
            mem.mixed_mask[llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO] = '1;
            mem.mixed_mask[llc_pkg::MIXED_DIRTY] = 1'b1;
        end
    end

    always_comb begin
        mem.mixed_wdata = '0;
        mem.mixed_wdata[llc_pkg::MIXED_TAG_HI:llc_pkg::MIXED_TAG_LO] = req_tag;
        mem.mixed_wdata[llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO] =
            is_flush ? llc_pkg::INVALID : req_state;
        mem.mixed_wdata[llc_pkg::MIXED_DIRTY] = is_flush ? 1'b0 : req_dirty;
    end

    // sharers cleared on flush
    assign mem.sharers_wdata = is_flush ? '0 : req_sharers;
    assign mem.line_wdata    = req_line;

    // round-robin pointer moves past the filled way
    assign mem.evict_we    = is_fill;
    assign mem.evict_wdata = (req_way == llc_pkg::way_t'(`LLC_WAYS - 1)) ? '0 :
                             req_way + llc_pkg::way_t'(1);

endmodule

//--- design/llc_localmem.sv
// banked tag/state, sharers and line RAMs per way
// plus the per-set eviction pointer array

`timescale 1ns/1ns
`include "llc_params.svh"

module llc_localmem (
    input logic      clk,
    input logic      rst,
    llc_mem_if.mem   mem
);

    localparam int BANK_DEPTH = 1 << `LLC_BANK_ADDR_BITS;
    localparam int NUM_SETS   = 1 << `LLC_SET_BITS;

    logic [`LLC_BANK_ADDR_BITS-1:0]                 bank_addr;
    logic [`LLC_SET_BITS-`LLC_BANK_ADDR_BITS-1:0]   bank_q;
    llc_pkg::mixed_t                                mixed_q [`LLC_WAYS][`LLC_BANKS];
    llc_pkg::sharers_t                              sharers_q [`LLC_WAYS][`LLC_BANKS];
    llc_pkg::line_t                                 line_q [`LLC_WAYS][`LLC_BANKS];
    llc_pkg::way_t                                  evict_arr [NUM_SETS];

    assign bank_addr = mem.set[`LLC_BANK_ADDR_BITS-1:0];

    for (genvar w = 0; w < `LLC_WAYS; w++) begin : g_way
        for (genvar b = 0; b < `LLC_BANKS; b++) begin : g_bank
            logic bank_hit;
            logic mixed_wr;
            logic sharers_wr;
            logic line_wr;

            assign bank_hit   = (mem.bank == b);
            assign mixed_wr   = mem.mixed_we[w] && bank_hit;
            assign sharers_wr = mem.sharers_we[w] && bank_hit;
            assign line_wr    = mem.line_we[w] && bank_hit;

            // tag, state and dirty under the decoded mask
            llc_sram_sp #(.WIDTH(`LLC_MIXED_BITS), .DEPTH(BANK_DEPTH)) mixed_ram (
                .clk   (clk),
                .ce    ((mem.rd_en && bank_hit) || mixed_wr),
                .we    (mixed_wr),
                .addr  (bank_addr),
                .d     (mem.mixed_wdata),
                .wmask (mem.mixed_mask),
                .q     (mixed_q[w][b])
            );

            llc_sram_sp #(.WIDTH(`LLC_SHARER_BITS), .DEPTH(BANK_DEPTH)) sharers_ram (
                .clk   (clk),
                .ce    ((mem.rd_en && bank_hit) || sharers_wr),
                .we    (sharers_wr),
                .addr  (bank_addr),
                .d     (mem.sharers_wdata),
                .wmask ({`LLC_SHARER_BITS{1'b1}}),
                .q     (sharers_q[w][b])
            );

            llc_sram_sp #(.WIDTH(`LLC_LINE_BITS), .DEPTH(BANK_DEPTH)) line_ram (
                .clk   (clk),
                .ce    ((mem.rd_en && bank_hit) || line_wr),
                .we    (line_wr),
                .addr  (bank_addr),
                .d     (mem.line_wdata),
                .wmask ({`LLC_LINE_BITS{1'b1}}),
                .q     (line_q[w][b])
            );
        end
    end

    // pick the bank that was addressed when the read was issued
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            mem.mixed_rd[w]   = mixed_q[w][bank_q];
            mem.sharers_rd[w] = sharers_q[w][bank_q];
            mem.line_rd[w]    = line_q[w][bank_q];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                evict_arr[s] <= '0;
            end
            mem.evict_rd <= '0;
            bank_q       <= '0;
        end else begin
            if (mem.evict_we) begin
                evict_arr[mem.set] <= mem.evict_wdata;
            end
            if (mem.rd_en) begin
                mem.evict_rd <= evict_arr[mem.set];
                bank_q       <= mem.bank;
            end
        end
    end

endmodule

//--- design/llc_lookup_result.sv
// tag compare over all ways, hit-way select and registered lookup response

`timescale 1ns/1ns
`include "llc_params.svh"

module llc_lookup_result (
    input  logic                clk,
    input  logic                rst,
    llc_mem_if.rsp              mem,
    output logic                rsp_valid,
    output logic                rsp_hit,
    output llc_pkg::way_t       rsp_way,
    output llc_pkg::llc_state_e rsp_state,
    output logic                rsp_dirty,
    output llc_pkg::sharers_t   rsp_sharers,
    output llc_pkg::line_t      rsp_line,
    output llc_pkg::way_t       rsp_evict_way
);

    logic                 lk_valid;
    llc_pkg::tag_t        lk_tag;
    logic [`LLC_WAYS-1:0] match;
    logic                 hit;
    llc_pkg::way_t        sel_way;
    llc_pkg::mixed_t      sel_mixed;

    // lookup strobe and tag travel alongside the RAM read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lk_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            lk_valid  <= mem.rd_en;
            rsp_valid <= lk_valid;
        end
    end

    always_ff @(posedge clk) begin
        lk_tag <= mem.lookup_tag;
    end

    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            match[w] = (mem.mixed_rd[w][llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO]
                        != llc_pkg::INVALID) &&
                       (mem.mixed_rd[w][llc_pkg::MIXED_TAG_HI:llc_pkg::MIXED_TAG_LO] == lk_tag);
        end
        hit = |match;
        // miss falls back to the eviction way, lowest match wins on a hit
        sel_way = mem.evict_rd;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                sel_way = llc_pkg::way_t'(w);
            end
        end
        sel_mixed = mem.mixed_rd[sel_way];
    end

    always_ff @(posedge clk) begin
        if (lk_valid) begin
            rsp_hit       <= hit;
            rsp_way       <= sel_way;
            rsp_state     <= hit ? llc_pkg::llc_state_e'(
                                 sel_mixed[llc_pkg::MIXED_STATE_HI:llc_pkg::MIXED_STATE_LO]) :
                             llc_pkg::INVALID;
            rsp_dirty     <= sel_mixed[llc_pkg::MIXED_DIRTY];
            rsp_sharers   <= mem.sharers_rd[sel_way];
            rsp_line      <= mem.line_rd[sel_way];
            rsp_evict_way <= mem.evict_rd;
        end
    end

endmodule

//--- design/llc_tag_top.sv
// cache slice store top: request decode, banked memory and lookup result

`timescale 1ns/1ns

module llc_tag_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  llc_pkg::llc_op_e    req_op,
    input  llc_pkg::set_t       req_set,
    input  llc_pkg::tag_t       req_tag,
    input  llc_pkg::way_t       req_way,
    input  llc_pkg::line_t      req_line,
    input  llc_pkg::llc_state_e req_state,
    input  logic                req_dirty,
    input  llc_pkg::sharers_t   req_sharers,
    output logic                rsp_valid,
    output logic                rsp_hit,
    output llc_pkg::way_t       rsp_way,
    output llc_pkg::llc_state_e rsp_state,
    output logic                rsp_dirty,
    output llc_pkg::sharers_t   rsp_sharers,
    output llc_pkg::line_t      rsp_line,
    output llc_pkg::way_t       rsp_evict_way
);

    llc_mem_if mem_bus ();

    llc_req_decode llc_req_decode_inst (
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_set     (req_set),
        .req_tag     (req_tag),
        .req_way     (req_way),
        .req_line    (req_line),
        .req_state   (req_state),
        .req_dirty   (req_dirty),
        .req_sharers (req_sharers),
        .mem         (mem_bus.ctrl)
    );

    llc_localmem llc_localmem_inst (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.mem)
    );

    llc_lookup_result llc_lookup_result_inst (
        .clk           (clk),
        .rst           (rst),
        .mem           (mem_bus.rsp),
        .rsp_valid     (rsp_valid),
        .rsp_hit       (rsp_hit),
        .rsp_way       (rsp_way),
        .rsp_state     (rsp_state),
        .rsp_dirty     (rsp_dirty),
        .rsp_sharers   (rsp_sharers),
        .rsp_line      (rsp_line),
        .rsp_evict_way (rsp_evict_way)
    );

endmodule

//--- verification/tb_clock_gen.sv
// free-running testbench clock

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- verification/llc_tag_checker.sv
// response timing and hit assertions, bound into the store top level

`timescale 1ns/1ns
`include "llc_params.svh"

module llc_tag_checker (
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input llc_pkg::llc_op_e    req_op,
    input logic                rsp_valid,
    input logic                rsp_hit,
    input llc_pkg::way_t       rsp_way,
    input llc_pkg::llc_state_e rsp_state
);

    logic lookup_req;

    assign lookup_req = req_valid && (req_op == llc_pkg::OP_LOOKUP);

    // response exactly two edges after the lookup strobe, and only then
    rsp_timing: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid == $past(lookup_req, 2))
        else $error("lookup response timing violated");

    // a hit can only come from a way holding a live line
    hit_state_live: assert property (@(posedge clk) disable iff (!rst)
        (rsp_valid && rsp_hit) |-> (rsp_state != llc_pkg::INVALID))
        else $error("hit reported with an invalid state");

    rsp_known: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> !$isunknown({rsp_hit, rsp_way}))
        else $error("hit flag or way unknown on a response");

endmodule

bind llc_tag_top llc_tag_checker llc_tag_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_op    (req_op),
    .rsp_valid (rsp_valid),
    .rsp_hit   (rsp_hit),
    .rsp_way   (rsp_way),
    .rsp_state (rsp_state)
);

//--- verification/llc_tag_tb.sv
// testbench for the cache store: LCG stimulus, reference model, response checks
// directed tests, a random mixed stream, watchdog and summary

`timescale 1ns/1ns
`include "llc_params.svh"

module llc_tag_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_SETS   = 1 << `LLC_SET_BITS;
    localparam int T2_ITERS   = 16;
    localparam int T3_ITERS   = 16;
    localparam int T4_ITERS   = 8;
    localparam int T1_REQS    = 32;
    localparam int T5_REQS    = 400;
    localparam int TOTAL_REQS = NUM_SETS * (`LLC_WAYS + 1) + T1_REQS + T2_ITERS * 2 +
                                T3_ITERS * 3 + T4_ITERS * 10 + T5_REQS + 5 * 2 + 3;
    localparam int MARGIN_NS  = 400;

    logic                clk;
    logic                rst;
    logic                req_valid;
    llc_pkg::llc_op_e    req_op;
    llc_pkg::set_t       req_set;
    llc_pkg::tag_t       req_tag;
    llc_pkg::way_t       req_way;
    llc_pkg::line_t      req_line;
    llc_pkg::llc_state_e req_state;
    logic                req_dirty;
    llc_pkg::sharers_t   req_sharers;
    logic                rsp_valid;
    logic                rsp_hit;
    llc_pkg::way_t       rsp_way;
    llc_pkg::llc_state_e rsp_state;
    logic                rsp_dirty;
    llc_pkg::sharers_t   rsp_sharers;
    llc_pkg::line_t      rsp_line;
    llc_pkg::way_t       rsp_evict_way;

    // reference model of every set and way
    llc_pkg::tag_t       m_tag [NUM_SETS][`LLC_WAYS];
    llc_pkg::llc_state_e m_state [NUM_SETS][`LLC_WAYS];
    logic                m_dirty [NUM_SETS][`LLC_WAYS];
    llc_pkg::sharers_t   m_sharers [NUM_SETS][`LLC_WAYS];
    llc_pkg::line_t      m_line [NUM_SETS][`LLC_WAYS];
    llc_pkg::way_t       m_ptr [NUM_SETS];

    // expected response {hit, way, state, dirty, sharers, line, evict}
    logic [43:0] exp_q [$];
    logic        lookup_pipe [2];
    logic [31:0] lcg_state;
    logic        live_only;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) tb_clock_gen_inst (.clk(clk));

    llc_tag_top llc_tag_top_inst (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_set       (req_set),
        .req_tag       (req_tag),
        .req_way       (req_way),
        .req_line      (req_line),
        .req_state     (req_state),
        .req_dirty     (req_dirty),
        .req_sharers   (req_sharers),
        .rsp_valid     (rsp_valid),
        .rsp_hit       (rsp_hit),
        .rsp_way       (rsp_way),
        .rsp_state     (rsp_state),
        .rsp_dirty     (rsp_dirty),
        .rsp_sharers   (rsp_sharers),
        .rsp_line      (rsp_line),
        .rsp_evict_way (rsp_evict_way)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t ns",
                     name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic check_response();
        logic [43:0] e;
        check_value("rsp_valid", 32'(lookup_pipe[1]), 32'(rsp_valid));
        if (lookup_pipe[1] && rsp_valid === 1'b1) begin
            e = exp_q.pop_front();
            check_value("rsp_hit", 32'(e[43]), 32'(rsp_hit));
            check_value("rsp_way", 32'(e[42:41]), 32'(rsp_way));
            check_value("rsp_state", 32'(e[40:39]), 32'(rsp_state));
            check_value("rsp_dirty", 32'(e[38]), 32'(rsp_dirty));
            check_value("rsp_sharers", 32'(e[37:34]), 32'(rsp_sharers));
            check_value("rsp_line", e[33:2], rsp_line);
            check_value("rsp_evict_way", 32'(e[1:0]), 32'(rsp_evict_way));
        end else if (lookup_pipe[1]) begin
            exp_q.delete(0);
        end
    endtask

    // model update in issue order; lookups see every earlier write
    task automatic model_apply(input llc_pkg::llc_op_e op, input int s, input int t,
                               input int w);
        logic                hit;
        int                  sel;
        llc_pkg::llc_state_e st;
        case (op)
            llc_pkg::OP_FILL: begin
                m_tag[s][w]     = req_tag;
                m_state[s][w]   = req_state;
                m_dirty[s][w]   = req_dirty;
                m_sharers[s][w] = req_sharers;
                m_line[s][w]    = req_line;
                m_ptr[s]        = llc_pkg::way_t'((w + 1) % `LLC_WAYS);
            end
            llc_pkg::OP_UPDATE: begin
                m_state[s][w]   = req_state;
                m_dirty[s][w]   = req_dirty;
                m_sharers[s][w] = req_sharers;
            end
            llc_pkg::OP_FLUSH: begin
                for (int i = 0; i < `LLC_WAYS; i++) begin
                    m_state[s][i]   = llc_pkg::INVALID;
                    m_dirty[s][i]   = 1'b0;
                    m_sharers[s][i] = '0;
                end
            end
            default: begin
                hit = 1'b0;
                sel = int'(m_ptr[s]);
                for (int i = `LLC_WAYS - 1; i >= 0; i--) begin
                    if (m_state[s][i] != llc_pkg::INVALID && m_tag[s][i] == t[9:0]) begin
                        hit = 1'b1;
                        sel = i;
                    end
                end
                st = hit ? m_state[s][sel] : llc_pkg::INVALID;
                exp_q.push_back({hit, 2'(sel), st, m_dirty[s][sel], m_sharers[s][sel],
                                 m_line[s][sel], m_ptr[s]});
            end
        endcase
    endtask

    // one request per cycle, driven 1 ns after the rising edge
    task automatic issue(input logic valid, input llc_pkg::llc_op_e op, input int s,
                         input int t, input int w);
        @(posedge clk);
        #1;
        check_response();
        lookup_pipe[1] = lookup_pipe[0];
        lookup_pipe[0] = valid && (op == llc_pkg::OP_LOOKUP);
        req_valid   = valid;
        req_op      = op;
        req_set     = llc_pkg::set_t'(s);
        req_tag     = llc_pkg::tag_t'(t);
        req_way     = llc_pkg::way_t'(w);
        req_line    = {rand16(), rand16()};
        req_state   = llc_pkg::llc_state_e'(rand16() % 4);
        req_dirty   = rand16() % 2 == 1;
        req_sharers = llc_pkg::sharers_t'(rand16());
        // directed fills and updates keep the line live
        if ((op == llc_pkg::OP_FILL || op == llc_pkg::OP_UPDATE) &&
            req_state == llc_pkg::INVALID && live_only) begin
            req_state = llc_pkg::MODIFIED;
        end
        if (valid) begin
            model_apply(op, s, t, w);
        end
    endtask

    task automatic drain_and_report(input string name, input int errors_before);
        issue(1'b0, llc_pkg::OP_LOOKUP, 0, 0, 0);
        issue(1'b0, llc_pkg::OP_LOOKUP, 0, 0, 0);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL (%0d mismatches)", name, errors - errors_before);
        end
    endtask

    initial begin
        #(TOTAL_REQS * CLK_PERIOD + MARGIN_NS);
        $display("watchdog timed out before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        int   e0;
        int   s;
        int   t;
        int   w;
        int   tags [`LLC_WAYS];
        logic [15:0] r;
        lcg_state      = 32'd47;
        live_only      = 1'b1;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        lookup_pipe[0] = 1'b0;
        lookup_pipe[1] = 1'b0;
        rst            = 1'b0;
        req_valid      = 1'b0;
        req_op         = llc_pkg::OP_LOOKUP;
        req_set        = '0;
        req_tag        = '0;
        req_way        = '0;
        req_line       = '0;
        req_state      = llc_pkg::INVALID;
        req_dirty      = 1'b0;
        req_sharers    = '0;
        for (int i = 0; i < NUM_SETS; i++) begin
            m_ptr[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        // write every way once so no RAM word stays unknown, then flush all
        e0 = errors;
        for (int i = 0; i < NUM_SETS; i++) begin
            for (int j = 0; j < `LLC_WAYS; j++) begin
                issue(1'b1, llc_pkg::OP_FILL, i, int'(rand16() % 1024), j);
            end
            issue(1'b1, llc_pkg::OP_FLUSH, i, 0, 0);
        end
        for (int i = 0; i < T1_REQS; i++) begin
            issue(1'b1, llc_pkg::OP_LOOKUP, int'(rand16() % 64), int'(rand16() % 1024), 0);
        end
        drain_and_report("flush_then_lookup", e0);

        e0 = errors;
        for (int i = 0; i < T2_ITERS; i++) begin
            s = int'(rand16() % 64);
            t = int'(rand16() % 1024);
            w = int'(rand16() % 4);
            issue(1'b1, llc_pkg::OP_FILL, s, t, w);
            issue(1'b1, llc_pkg::OP_LOOKUP, s, t, 0);
        end
        drain_and_report("fill_then_lookup", e0);

        e0 = errors;
        for (int i = 0; i < T3_ITERS; i++) begin
            s = int'(rand16() % 64);
            t = int'(rand16() % 1024);
            w = int'(rand16() % 4);
            issue(1'b1, llc_pkg::OP_FILL, s, t, w);
            // tag on the bus differs, the mask must keep the stored one
            issue(1'b1, llc_pkg::OP_UPDATE, s, (t + 1) % 1024, w);
            issue(1'b1, llc_pkg::OP_LOOKUP, s, t, 0);
        end
        drain_and_report("masked_update", e0);

        e0 = errors;
        for (int i = 0; i < T4_ITERS; i++) begin
            s = int'(rand16() % 64);
            for (int j = 0; j < `LLC_WAYS; j++) begin
                tags[j] = int'(rand16() % 1024);
                issue(1'b1, llc_pkg::OP_FILL, s, tags[j], j);
            end
            w = int'(rand16() % 4);
            issue(1'b1, llc_pkg::OP_FILL, s, tags[w], w);
            issue(1'b1, llc_pkg::OP_FLUSH, s, 0, 0);
            for (int j = 0; j < `LLC_WAYS; j++) begin
                issue(1'b1, llc_pkg::OP_LOOKUP, s, tags[j], 0);
            end
        end
        drain_and_report("flush_filled_set", e0);

        // random fills and updates may also write INVALID
        live_only = 1'b0;
        e0 = errors;
        for (int i = 0; i < T5_REQS; i++) begin
            s = int'(rand16() % 64);
            w = int'(rand16() % 4);
            r = rand16();
            // half the lookups reuse a stored tag so hits are frequent
            t = (r[0]) ? int'(m_tag[s][w]) : int'(rand16() % 1024);
            issue(1'b1, llc_pkg::llc_op_e'(r[3:2]), s, t, w);
        end
        drain_and_report("random_mixed_stream", e0);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- llc_tag_top.f
+incdir+design
design/llc_pkg.sv
design/llc_mem_if.sv
design/llc_sram_sp.sv
design/llc_req_decode.sv
design/llc_localmem.sv
design/llc_lookup_result.sv
design/llc_tag_top.sv
verification/tb_clock_gen.sv
verification/llc_tag_checker.sv
verification/llc_tag_tb.sv

//--- Makefile
TOP = llc_tag_tb
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f llc_tag_top.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f llc_tag_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
